/* src/decode_pkg.sv */
package decode_pkg;

	//////////////////////////////////////////////////
	// widths and counts
	//////////////////////////////////////////////////
	localparam int data_width     = 32;
	localparam int reg_addr_width = 5;
	localparam int reg_count      = 32;

	// opcodes, instr[31:26]
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_jal   = 6'h03;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addi  = 6'h08;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;
	localparam logic [5:0] op_halt  = 6'h3f;

	// r-type funct, instr[5:0]
	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_srl = 6'h02;
	localparam logic [5:0] fn_jr  = 6'h08;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or  = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	localparam logic [3:0] alu_nop = 4'd0;
	localparam logic [3:0] alu_add = 4'd1;
	localparam logic [3:0] alu_sub = 4'd2;
	localparam logic [3:0] alu_and = 4'd3;
	localparam logic [3:0] alu_or  = 4'd4;
	localparam logic [3:0] alu_slt = 4'd5;
	localparam logic [3:0] alu_sll = 4'd6;
	localparam logic [3:0] alu_srl = 4'd7;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	//////////////////////////////////////////////////
	// control bundles
	//////////////////////////////////////////////////
	typedef struct packed {
		logic       reg_dst;
		logic       alu_src;
		logic [3:0] alu_op;
		logic       shift_imm;
		logic       jump;
		logic       jump_reg;
		logic       link;
	} ex_ctrl_t;

	typedef struct packed {
		logic       mem_read;
		logic       mem_write;
		logic       branch_eq;
		logic       branch_ne;
		logic [1:0] size; // 00 byte, 01 half, 10 word
		logic       unsigned_load;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ctrl_bundle_t;

	//////////////////////////////////////////////////
	// stage payloads
	//////////////////////////////////////////////////
	typedef struct packed {
		logic [data_width-1:0] pc_plus4;
		logic [data_width-1:0] instr;
		logic                  halt_req;
	} if_id_t;

	typedef struct packed {
		logic [data_width-1:0]     pc_plus4;
		logic [data_width-1:0]     reg1;
		logic [data_width-1:0]     reg2;
		logic [data_width-1:0]     sign_ext;
		logic [reg_addr_width-1:0] rs;
		logic [reg_addr_width-1:0] rt;
		logic [reg_addr_width-1:0] rd;
		logic [reg_addr_width-1:0] shamt;
		ctrl_bundle_t              ctrl;
		logic                      halt;
	} id_ex_t;

	typedef struct packed {
		logic                      we;
		logic [reg_addr_width-1:0] addr;
		logic [data_width-1:0]     data;
	} wb_port_t;

	typedef struct packed {
		logic                  jump;
		logic                  jump_reg;
		logic [data_width-1:0] target;
	} jump_t;

	// debug bus
	typedef struct packed {
		logic [7:0]            araddr;
		logic                  arvalid;
		logic                  rready;
		logic [7:0]            awaddr;
		logic                  awvalid;
		logic [data_width-1:0] wdata;
		logic                  wvalid;
		logic                  bready;
	} axil_req_t;

	typedef struct packed {
		logic                  arready;
		logic [data_width-1:0] rdata;
		logic [1:0]            rresp;
		logic                  rvalid;
		logic                  awready;
		logic                  wready;
		logic [1:0]            bresp;
		logic                  bvalid;
	} axil_rsp_t;

endpackage

/* src/stage_reg.sv */
`timescale 1ns/1ns

module stage_reg #(
	parameter type payload_t = logic
)(
	input  logic     clk,
	input  logic     reset,
	input  logic     en,     // global stage enable
	input  logic     hold,   // keep current content
	input  logic     bubble, // load all zeros
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			q <= '0;
		else if (en)
		begin
			if (bubble)
				q <= '0;
			else if (!hold)
				q <= d;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// hold comes from a flush-masked stall, so it can never meet a flush
	a_hold_vs_bubble: assert property (
		@(posedge clk) disable iff (reset)
		en |-> !(hold && bubble)
	);

endmodule

/* src/control_decoder.sv */
`timescale 1ns/1ns

module control_decoder
	import decode_pkg::*;
(
	input  logic [5:0]   opcode,
	input  logic [5:0]   funct,
	output ctrl_bundle_t ctrl,
	output logic         halt
);

	always_comb
	begin
		ctrl = '0;
		halt = 1'b0;
		case (opcode)
			op_rtype:
			begin
				ctrl.ex.reg_dst   = 1'b1;
				ctrl.wb.reg_write = 1'b1;
				case (funct)
					fn_add: ctrl.ex.alu_op = alu_add;
					fn_sub: ctrl.ex.alu_op = alu_sub;
					fn_and: ctrl.ex.alu_op = alu_and;
					fn_or:  ctrl.ex.alu_op = alu_or;
					fn_slt: ctrl.ex.alu_op = alu_slt;
					fn_sll:
					begin
						ctrl.ex.alu_op    = alu_sll;
						ctrl.ex.shift_imm = 1'b1; // shamt, not rs
					end
					fn_srl:
					begin
						ctrl.ex.alu_op    = alu_srl;
						ctrl.ex.shift_imm = 1'b1;
					end
					fn_jr:
					begin
						ctrl = '0; // no write back for jr
						ctrl.ex.jump_reg = 1'b1;
					end
					default: ctrl = '0;
				endcase
			end
			op_addi, op_andi, op_ori:
			begin
				ctrl.ex.alu_src   = 1'b1;
				ctrl.wb.reg_write = 1'b1;
				ctrl.ex.alu_op    = (opcode == op_addi) ? alu_add :
				                    (opcode == op_andi) ? alu_and : alu_or;
			end
			op_lw:
			begin
				ctrl.ex.alu_src    = 1'b1;
				ctrl.ex.alu_op     = alu_add; // base + offset
				ctrl.mem.mem_read  = 1'b1;
				ctrl.mem.size      = 2'b10; // word
				ctrl.wb.reg_write  = 1'b1;
				ctrl.wb.mem_to_reg = 1'b1;
			end
			op_sw:
			begin
				ctrl.ex.alu_src    = 1'b1;
				ctrl.ex.alu_op     = alu_add;
				ctrl.mem.mem_write = 1'b1;
				ctrl.mem.size      = 2'b10;
			end
			op_beq:
			begin
				ctrl.ex.alu_op     = alu_sub;
				ctrl.mem.branch_eq = 1'b1;
			end
			op_bne:
			begin
				ctrl.ex.alu_op     = alu_sub;
				ctrl.mem.branch_ne = 1'b1;
			end
			op_j: ctrl.ex.jump = 1'b1;
			op_jal:
			begin
				ctrl.ex.jump      = 1'b1;
				ctrl.ex.link      = 1'b1; // pc+4 into r31 later on
				ctrl.wb.reg_write = 1'b1;
			end
			op_halt: halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

/* src/register_file.sv */
`timescale 1ns/1ns

module register_file
	import decode_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic [reg_addr_width-1:0] rs_addr,
	input  logic [reg_addr_width-1:0] rt_addr,
	input  logic [reg_addr_width-1:0] dbg_addr,
	input  wb_port_t                  wb,
	output logic [data_width-1:0]     rs_data,
	output logic [data_width-1:0]     rt_data,
	output logic [data_width-1:0]     dbg_data
);

	logic [data_width-1:0] regs [reg_count];

	// write port, not gated by the stage enable
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end
		else if (wb.we && wb.addr != '0)
			regs[wb.addr] <= wb.data;
	end

	//////////////////////////////////////////////////
	// read ports with write bypass
	//////////////////////////////////////////////////

	// r0 first so a write to it is never bypassed
	assign rs_data = (rs_addr == '0) ? '0 :
	                 (wb.we && wb.addr == rs_addr) ? wb.data : regs[rs_addr];

	assign rt_data = (rt_addr == '0) ? '0 :
	                 (wb.we && wb.addr == rt_addr) ? wb.data : regs[rt_addr];

	assign dbg_data = (dbg_addr == '0) ? '0 :
	                  (wb.we && wb.addr == dbg_addr) ? wb.data : regs[dbg_addr];

	// r0 stays zero whatever write-back attempts
	a_r0_fixed: assert property (
		@(posedge clk) disable iff (reset)
		(wb.we && wb.addr == '0) |=> $stable(regs[0])
	);

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage
	import decode_pkg::*;
(
	input  if_id_t                    if_id,
	input  id_ex_t                    id_ex_q,  // instruction one stage ahead
	input  logic [data_width-1:0]     rs_data,
	input  logic [data_width-1:0]     rt_data,
	input  logic                      flush,
	output logic [reg_addr_width-1:0] rs_addr,
	output logic [reg_addr_width-1:0] rt_addr,
	output id_ex_t                    id_ex_d,
	output jump_t                     jump,
	output logic                      stall
);

	logic [5:0]                opcode;
	logic [5:0]                funct;
	logic [reg_addr_width-1:0] rs;
	logic [reg_addr_width-1:0] rt;
	logic [reg_addr_width-1:0] rd;
	logic [reg_addr_width-1:0] shamt;
	logic [15:0]               imm;
	ctrl_bundle_t              dec_ctrl;
	logic                      dec_halt;
	logic                      load_use;
	logic                      jump_off;

	//////////////////////////////////////////////////
	// field split
	//////////////////////////////////////////////////
	assign opcode = if_id.instr[31:26];
	assign rs     = if_id.instr[25:21];
	assign rt     = if_id.instr[20:16];
	assign rd     = if_id.instr[15:11];
	assign shamt  = if_id.instr[10:6];
	assign funct  = if_id.instr[5:0];
	assign imm    = if_id.instr[15:0];

	assign rs_addr = rs;
	assign rt_addr = rt;

	control_decoder u_control_decoder (
		.opcode (opcode),
		.funct  (funct),
		.ctrl   (dec_ctrl),
		.halt   (dec_halt)
	);

	//////////////////////////////////////////////////
	// load-use hazard
	//////////////////////////////////////////////////

	// load in id/ex whose destination feeds this instruction
	assign load_use = id_ex_q.ctrl.mem.mem_read && (id_ex_q.rt != '0) &&
	                  ((id_ex_q.rt == rs) || (id_ex_q.rt == rt));

	assign stall = load_use && !flush;

	// next id/ex content, control cleared for a bubble
	always_comb
	begin
		id_ex_d.pc_plus4 = if_id.pc_plus4;
		id_ex_d.reg1     = rs_data;
		id_ex_d.reg2     = rt_data;
		id_ex_d.sign_ext = {{(data_width-16){imm[15]}}, imm};
		id_ex_d.rs       = rs;
		id_ex_d.rt       = rt;
		id_ex_d.rd       = rd;
		id_ex_d.shamt    = shamt;
		id_ex_d.ctrl     = stall ? '0 : dec_ctrl;
		id_ex_d.halt     = stall ? 1'b0 : (dec_halt | if_id.halt_req); // halt_req from debug
	end

	//////////////////////////////////////////////////
	// jump targets
	//////////////////////////////////////////////////
	assign jump_off = flush || stall;

	always_comb
	begin
		jump = '0;
		if (!jump_off)
		begin
			jump.jump     = dec_ctrl.ex.jump;
			jump.jump_reg = dec_ctrl.ex.jump_reg;
			if (dec_ctrl.ex.jump_reg)
				jump.target = rs_data; // jr
			else if (dec_ctrl.ex.jump)
				jump.target = {if_id.pc_plus4[31:28], if_id.instr[25:0], 2'b00};
		end
	end

endmodule

/* src/debug_axil_port.sv */
`timescale 1ns/1ns

module debug_axil_port
	import decode_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  axil_req_t                 req,
	input  logic [data_width-1:0]     dbg_data,
	output axil_rsp_t                 rsp,
	output logic [reg_addr_width-1:0] dbg_addr
);

	logic                      rvalid;
	logic [data_width-1:0]     rdata;
	logic [reg_addr_width-1:0] rd_idx;  // index of the pending read
	logic                      ar_hs;
	logic                      aw_done;
	logic                      w_done;
	logic                      aw_hs;
	logic                      w_hs;
	logic                      bvalid;

	//////////////////////////////////////////////////
	// read channel
	//////////////////////////////////////////////////
	assign ar_hs = req.arvalid && !rvalid;

	// word addressed, 4 bytes per register
	assign dbg_addr = rvalid ? rd_idx : req.araddr[6:2];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rvalid <= 1'b0;
		else if (ar_hs)
			rvalid <= 1'b1;
		else if (req.rready)
			rvalid <= 1'b0;
	end

	// read payload, captured at the ar handshake
	always_ff @(posedge clk)
	begin
		if (ar_hs)
		begin
			rd_idx <= req.araddr[6:2];
			rdata  <= dbg_data;
		end
	end

	//////////////////////////////////////////////////
	// write channel, always rejected
	//////////////////////////////////////////////////
	assign aw_hs = req.awvalid && !aw_done && !bvalid;
	assign w_hs  = req.wvalid && !w_done && !bvalid;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			aw_done <= 1'b0;
			w_done  <= 1'b0;
			bvalid  <= 1'b0;
		end
		else if ((aw_done || aw_hs) && (w_done || w_hs))
		begin
			aw_done <= 1'b0;
			w_done  <= 1'b0;
			bvalid  <= 1'b1;
		end
		else
		begin
			aw_done <= aw_done || aw_hs;
			w_done  <= w_done || w_hs;
			if (req.bready)
				bvalid <= 1'b0;
		end
	end

	assign rsp.arready = !rvalid;
	assign rsp.rdata   = rdata;
	assign rsp.rresp   = resp_okay;
	assign rsp.rvalid  = rvalid;
	assign rsp.awready = !aw_done && !bvalid;
	assign rsp.wready  = !w_done && !bvalid;
	assign rsp.bresp   = resp_slverr;
	assign rsp.bvalid  = bvalid;

	// response must wait for the host
	a_rvalid_hold: assert property (
		@(posedge clk) disable iff (reset)
		(rvalid && !req.rready) |=> (rvalid && $stable(rdata))
	);

	a_bvalid_hold: assert property (
		@(posedge clk) disable iff (reset)
		(bvalid && !req.bready) |=> bvalid
	);

endmodule

/* src/decode_top.sv */
`timescale 1ns/1ns

module decode_top
	import decode_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      stage_en,
	input  logic      flush,
	input  if_id_t    fetch,
	input  wb_port_t  wb,
	input  axil_req_t axil_req,
	output id_ex_t    id_ex,
	output jump_t     jump,
	output logic      stall,
	output axil_rsp_t axil_rsp
);

	if_id_t                    if_id_q;
	id_ex_t                    id_ex_d;
	logic [reg_addr_width-1:0] rs_addr;
	logic [reg_addr_width-1:0] rt_addr;
	logic [reg_addr_width-1:0] dbg_addr;
	logic [data_width-1:0]     rs_data;
	logic [data_width-1:0]     rt_data;
	logic [data_width-1:0]     dbg_data;

	//////////////////////////////////////////////////
	// input side
	//////////////////////////////////////////////////
	stage_reg #(
		.payload_t (if_id_t)
	) if_id_reg (
		.clk    (clk),
		.reset  (reset),
		.en     (stage_en),
		.hold   (stall),  // already low under flush
		.bubble (flush),
		.d      (fetch),
		.q      (if_id_q)
	);

	//////////////////////////////////////////////////
	// processing
	//////////////////////////////////////////////////
	decode_stage u_decode_stage (
		.if_id   (if_id_q),
		.id_ex_q (id_ex),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.flush   (flush),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.id_ex_d (id_ex_d),
		.jump    (jump),
		.stall   (stall)
	);

	register_file u_register_file (
		.clk      (clk),
		.reset    (reset),
		.rs_addr  (rs_addr),
		.rt_addr  (rt_addr),
		.dbg_addr (dbg_addr),
		.wb       (wb),
		.rs_data  (rs_data),
		.rt_data  (rt_data),
		.dbg_data (dbg_data)
	);

	//////////////////////////////////////////////////
	// output side
	//////////////////////////////////////////////////
	stage_reg #(
		.payload_t (id_ex_t)
	) id_ex_reg (
		.clk    (clk),
		.reset  (reset),
		.en     (stage_en),
		.hold   (1'b0),   // never holds, bubbles come via ctrl
		.bubble (flush),
		.d      (id_ex_d),
		.q      (id_ex)
	);

	debug_axil_port u_debug_axil_port (
		.clk      (clk),
		.reset    (reset),
		.req      (axil_req),
		.dbg_data (dbg_data),
		.rsp      (axil_rsp),
		.dbg_addr (dbg_addr)
	);

endmodule

/* tests/decode_tb.sv */
`timescale 1ns/1ns

module decode_tb
	import decode_pkg::*;
();

	localparam int clk_period = 40;
	localparam int vec_count  = 24;
	localparam int vec_words  = 12; // hex words per line
	localparam int axi_reads  = 12;

	logic      clk;
	logic      reset;
	logic      stage_en;
	logic      flush;
	if_id_t    fetch;
	wb_port_t  wb;
	axil_req_t axil_req;
	id_ex_t    id_ex;
	jump_t     jump;
	logic      stall;
	axil_rsp_t axil_rsp;

	logic [31:0] vec_mem [vec_count*vec_words];
	logic [31:0] shadow [reg_count]; // register contents seen through wb
	if_id_t      exp_if_id;          // fetch word expected in if/id
	if_id_t      exp_id_ex;          // fetch word expected behind id/ex
	integer      seed;

	decode_top DUT (
		.clk      (clk),
		.reset    (reset),
		.stage_en (stage_en),
		.flush    (flush),
		.fetch    (fetch),
		.wb       (wb),
		.axil_req (axil_req),
		.id_ex    (id_ex),
		.jump     (jump),
		.stall    (stall),
		.axil_rsp (axil_rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period/2) clk = ~clk;
	end

	initial
	begin
		#((vec_count + 200) * clk_period);
		abort_run("timeout: the test did not reach its end in the expected time");
	end

	//////////////////////////////////////////////////
	// reporting
	//////////////////////////////////////////////////
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			abort_run($sformatf("MISMATCH at %0t ns: %s expected %h, got %h",
				$time, name, expected, actual));
		end
	endtask

	//////////////////////////////////////////////////
	// vector phase
	//////////////////////////////////////////////////
	task automatic apply_vector(input int i);
		int         base;
		logic [3:0] ctl;
		base = i * vec_words;
		ctl  = vec_mem[base][3:0];
		stage_en       <= ctl[3];
		flush          <= ctl[2];
		fetch.halt_req <= ctl[1];
		fetch.pc_plus4 <= vec_mem[base+1];
		fetch.instr    <= vec_mem[base+2];
		wb.we          <= ctl[0];
		wb.addr        <= vec_mem[base+3][4:0];
		wb.data        <= vec_mem[base+4];
		if (ctl[0] && vec_mem[base+3][4:0] != 5'd0)
			shadow[vec_mem[base+3][4:0]] = vec_mem[base+4]; // r0 never written
	endtask

	// moves the expected fetch words as the next edge will
	task automatic track_pipeline(input int i);
		int         base;
		logic [3:0] ctl;
		logic [3:0] flags;
		base  = i * vec_words;
		ctl   = vec_mem[base][3:0];
		flags = vec_mem[base+10][3:0];
		if (ctl[3])
		begin
			if (ctl[2])
			begin
				exp_if_id = '0;
				exp_id_ex = '0;
			end
			else
			begin
				exp_id_ex = exp_if_id; // a bubble keeps the decoded fields
				if (!flags[3])
				begin
					exp_if_id.pc_plus4 = vec_mem[base+1];
					exp_if_id.instr    = vec_mem[base+2];
				end
			end
		end
	endtask

	task automatic check_vector(input int i);
		int         base;
		logic [3:0] ctl;
		logic [3:0] flags;
		base  = i * vec_words;
		ctl   = vec_mem[base][3:0];
		flags = vec_mem[base+10][3:0];
		check_value("id_ex.pc_plus4", exp_id_ex.pc_plus4, id_ex.pc_plus4);
		check_value("id_ex.rs", exp_id_ex.instr[25:21], id_ex.rs);
		check_value("id_ex.rt", exp_id_ex.instr[20:16], id_ex.rt);
		check_value("id_ex.shamt", exp_id_ex.instr[10:6], id_ex.shamt);
		check_value("id_ex.reg1", vec_mem[base+5], id_ex.reg1);
		check_value("id_ex.reg2", vec_mem[base+6], id_ex.reg2);
		check_value("id_ex.sign_ext", vec_mem[base+7], id_ex.sign_ext);
		check_value("id_ex.rd", vec_mem[base+8], id_ex.rd);
		check_value("id_ex.ctrl", vec_mem[base+9], id_ex.ctrl);
		check_value("id_ex.halt", flags[0], id_ex.halt);
		check_value("stall", flags[3], stall);
		check_value("jump.jump", flags[2], jump.jump);
		check_value("jump.jump_reg", flags[1], jump.jump_reg);
		// target only defined for jumps, zero under flush or stall
		if (flags[2] || flags[1] || flags[3] || ctl[2])
			check_value("jump.target", vec_mem[base+11], jump.target);
	endtask

	//////////////////////////////////////////////////
	// debug port phase
	//////////////////////////////////////////////////
	task automatic axi_read_check(input logic [4:0] idx, input int delay);
		logic [31:0] expected;
		expected = shadow[idx];
		@(posedge clk);
		axil_req.araddr  <= {1'b0, idx, 2'b00};
		axil_req.arvalid <= 1'b1;
		@(negedge clk);
		while (!axil_rsp.arready)
			@(negedge clk);
		@(posedge clk); // ar handshake
		axil_req.arvalid <= 1'b0;
		@(negedge clk);
		check_value("axil_rsp.rvalid", 1'b1, axil_rsp.rvalid);
		check_value("axil_rsp.rresp", resp_okay, axil_rsp.rresp);
		check_value("axil_rsp.rdata", expected, axil_rsp.rdata);
		repeat (delay)
		begin
			@(posedge clk);
			@(negedge clk);
			check_value("axil_rsp.rvalid", 1'b1, axil_rsp.rvalid);
			check_value("axil_rsp.arready", 1'b0, axil_rsp.arready);
			check_value("axil_rsp.rdata", expected, axil_rsp.rdata);
		end
		@(posedge clk);
		axil_req.rready <= 1'b1;
		@(posedge clk);
		axil_req.rready <= 1'b0;
		@(negedge clk);
		check_value("axil_rsp.rvalid", 1'b0, axil_rsp.rvalid);
		check_value("axil_rsp.arready", 1'b1, axil_rsp.arready);
	endtask

	task automatic axi_write_check(input logic [4:0] idx, input logic [31:0] data);
		@(posedge clk);
		axil_req.awaddr  <= {1'b0, idx, 2'b00};
		axil_req.awvalid <= 1'b1;
		axil_req.wdata   <= data;
		axil_req.wvalid  <= 1'b1;
		@(negedge clk);
		check_value("axil_rsp.awready", 1'b1, axil_rsp.awready);
		check_value("axil_rsp.wready", 1'b1, axil_rsp.wready);
		@(posedge clk); // both beats taken here
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		@(negedge clk);
		check_value("axil_rsp.bvalid", 1'b1, axil_rsp.bvalid);
		check_value("axil_rsp.bresp", resp_slverr, axil_rsp.bresp);
		check_value("axil_rsp.awready", 1'b0, axil_rsp.awready);
		@(posedge clk);
		axil_req.bready <= 1'b1;
		@(posedge clk);
		axil_req.bready <= 1'b0;
		@(negedge clk);
		check_value("axil_rsp.bvalid", 1'b0, axil_rsp.bvalid);
	endtask

	initial
	begin
		logic [4:0] idx;
		int         delay;
		seed      = 32'h9eb3;
		exp_if_id = '0;
		exp_id_ex = '0;
		for (int r = 0; r < reg_count; r++)
			shadow[r] = '0;
		reset    = 1'b1;
		stage_en = 1'b0;
		flush    = 1'b0;
		fetch    = '0;
		wb       = '0;
		axil_req = '0;
		$readmemh("tests/decode_input.txt", vec_mem);
		if (vec_mem[vec_count*vec_words-1] === 'x)
			abort_run("the vector file tests/decode_input.txt is missing or too short");
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < vec_count; i++)
		begin
			@(posedge clk);
			apply_vector(i);
			@(negedge clk);
			check_vector(i);
			track_pipeline(i);
		end
		@(posedge clk);
		stage_en <= 1'b0;
		flush    <= 1'b0;
		fetch    <= '0;
		wb       <= '0;
		for (int n = 0; n < axi_reads; n++)
		begin
			idx   = $random(seed) & 31;
			delay = $random(seed) & 3; // rready back-pressure
			axi_read_check(idx, delay);
		end
		axi_write_check(5'd4, $random(seed));
		axi_read_check(5'd4, 1); // write must leave r4 alone
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* tests/decode_input.txt */
// ctl(en fl hreq we) pc_plus4 instr wb_addr wb_data | expected: reg1 reg2 sign_ext rd ctrl
// flags(stall jump jump_reg halt) target ; one line per clock, checked before the next edge
// register setup through write-back, pipeline disabled
1 00000000 00000000 01 00000011 00000000 00000000 00000000 00 00000 0 00000000
1 00000000 00000000 02 00000022 00000000 00000000 00000000 00 00000 0 00000000
1 00000000 00000000 03 FFFFFFF0 00000000 00000000 00000000 00 00000 0 00000000
1 00000000 00000000 04 00001234 00000000 00000000 00000000 00 00000 0 00000000
// add, addi, sll, then a disabled cycle and an or with write bypass
8 00400004 00222820 00 00000000 00000000 00000000 00000000 00 00000 0 00000000
8 00400008 2066FFF8 00 00000000 00000000 00000000 00000000 00 4D002 0 00000000
9 0040000C 00023900 08 CAFEF00D 00000011 00000022 00002820 05 42002 0 00000000
0 00000000 00000000 00 00000000 FFFFFFF0 00000000 FFFFFFF8 1F 22002 0 00000000
8 00400010 010A4825 00 00000000 FFFFFFF0 00000000 FFFFFFF8 1F 22002 0 00000000
9 00400014 8C2B0004 0A 0BADBEEF 00000000 00000022 00003900 07 4D002 0 00000000
// lw then a dependent add, one stall and one bubble
8 00400018 01626020 00 00000000 CAFEF00D 0BADBEEF 00004825 09 48002 0 00000000
8 0040001C 08100010 00 00000000 00000011 00000000 00000004 00 22113 8 00000000
8 0040001C 08100010 00 00000000 00000000 00000022 00006020 0C 00000 0 00000000
// j, jal, jr, halt, ori
8 80000020 0C000040 00 00000000 00000000 00000022 00006020 0C 42002 4 00400040
8 00400024 00800008 00 00000000 00000000 00000000 00000010 00 00800 4 80000100
8 00400028 FC000000 00 00000000 00000000 00000000 00000040 00 00A02 2 00001234
8 0040002C 344D8001 00 00000000 00001234 00000000 00000008 00 00400 0 00000000
8 00400030 08000123 00 00000000 00000000 00000000 00000000 00 00000 1 00000000
// flush with a j in if/id
C 00400034 200E0005 00 00000000 00000022 00000000 FFFF8001 10 28002 0 00000000
8 00400034 200E0005 00 00000000 00000000 00000000 00000000 00 00000 0 00000000
// debug halt request, write to r0 ignored
A 00400038 00047822 00 00000000 00000000 00000000 00000000 00 4D002 0 00000000
9 00000000 00000000 00 FFFFFFFF 00000000 00000000 00000005 00 22002 0 00000000
8 00000000 00000000 00 00000000 00000000 00001234 00007822 0F 44002 1 00000000
0 00000000 00000000 00 00000000 00000000 00000000 00000000 00 4D002 0 00000000

/* files.f */
src/decode_pkg.sv
src/stage_reg.sv
src/control_decoder.sv
src/register_file.sv
src/decode_stage.sv
src/debug_axil_port.sv
src/decode_top.sv
tests/decode_tb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - src/decode_pkg.sv
  - src/stage_reg.sv
  - src/control_decoder.sv
  - src/register_file.sv
  - src/decode_stage.sv
  - src/debug_axil_port.sv
  - src/decode_top.sv
  - target: test
    files:
      - tests/decode_tb.sv
